//--- rtl/regbridge_pkg.sv
package regbridge_pkg;

    // widths that carry a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [3:0]  nibble_t;

    // clock cycles per serial bit
    localparam int CLKS_PER_BAUD = 8;
    localparam int REG_DEPTH     = 256;

    // command, reply and terminator characters
    localparam byte_t CHAR_READ  = 8'h52;
    localparam byte_t CHAR_WRITE = 8'h57;
    localparam byte_t CHAR_DATA  = 8'h44;
    localparam byte_t CHAR_CR    = 8'h0D;
    localparam byte_t CHAR_LF    = 8'h0A;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        PARSE_IDLE,
        PARSE_READ,
        PARSE_WRITE
    } parse_state_t;

endpackage

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 rx_i,
    output regbridge_pkg::byte_t data_o,
    output logic                 valid_o
);
    import regbridge_pkg::*;

    typedef logic [$clog2(2 * CLKS_PER_BAUD)-1:0] baud_cnt_t;

    logic      rx_meta;
    logic      rx_sync;
    rx_state_t state;
    baud_cnt_t baud_cnt;
    logic [2:0] bit_cnt;
    logic      sample;

    assign sample = (baud_cnt == '0);

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_o  <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rx_sync) begin
                        // skip the start bit and land mid bit 0
                        baud_cnt <= baud_cnt_t'(CLKS_PER_BAUD + CLKS_PER_BAUD / 2 - 1);
                        bit_cnt  <= '0;
                        state    <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        baud_cnt <= baud_cnt_t'(CLKS_PER_BAUD - 1);
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                RX_STOP: begin
                    if (sample) begin
                        // a low stop bit means a broken frame
                        valid_o <= rx_sync;
                        state   <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if ((state == RX_DATA) && sample) begin
            data_o <= {rx_sync, data_o[7:1]};
        end
    end

endmodule

//--- rtl/request_parser.sv
`timescale 1ns/1ps

module request_parser (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  regbridge_pkg::byte_t byte_i,
    input  logic                 byte_valid_i,
    output regbridge_pkg::word_t addr_o,
    output regbridge_pkg::word_t data_o,
    output logic                 write_o,
    output logic                 valid_o
);
    import regbridge_pkg::*;

    parse_state_t state;
    logic [3:0]   digit_cnt;
    logic         is_hex;
    logic         is_term;
    logic         at_term;
    nibble_t      nib;

    // hex digit decode, upper case only
    always_comb begin
        is_hex = 1'b1;
        nib    = '0;
        if ((byte_i >= "0") && (byte_i <= "9")) begin
            nib = nibble_t'(byte_i - "0");
        end else if ((byte_i >= "A") && (byte_i <= "F")) begin
            nib = nibble_t'(byte_i - "A" + 8'd10);
        end else begin
            is_hex = 1'b0;
        end
    end

    assign is_term = (byte_i == CHAR_CR) || (byte_i == CHAR_LF);

    // read carries 4 digits, write carries 8
    assign at_term = (state == PARSE_READ) ? (digit_cnt == 4'd4) : (digit_cnt == 4'd8);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state     <= PARSE_IDLE;
            digit_cnt <= '0;
            write_o   <= 1'b0;
            valid_o   <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (byte_valid_i) begin
                case (state)
                    PARSE_IDLE: begin
                        digit_cnt <= '0;
                        if (byte_i == CHAR_READ) begin
                            state <= PARSE_READ;
                        end else if (byte_i == CHAR_WRITE) begin
                            state <= PARSE_WRITE;
                        end
                    end
                    PARSE_READ, PARSE_WRITE: begin
                        if (at_term) begin
                            // anything but CR or LF drops the command
                            state   <= PARSE_IDLE;
                            valid_o <= is_term;
                            write_o <= (state == PARSE_WRITE);
                        end else if (is_hex) begin
                            digit_cnt <= digit_cnt + 4'd1;
                        end else begin
                            state <= PARSE_IDLE;
                        end
                    end
                    default: state <= PARSE_IDLE;
                endcase
            end
        end
    end

    // first four digits are the address, the rest the data
    always_ff @(posedge clk) begin
        if (byte_valid_i && (state != PARSE_IDLE) && !at_term && is_hex) begin
            if (digit_cnt < 4'd4) begin
                addr_o <= {addr_o[11:0], nib};
            end else begin
                data_o <= {data_o[11:0], nib};
            end
        end
    end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  regbridge_pkg::word_t addr_i,
    input  regbridge_pkg::word_t data_i,
    input  logic                 write_i,
    input  logic                 valid_i,
    output regbridge_pkg::word_t rd_data_o,
    output logic                 rd_valid_o
);
    import regbridge_pkg::*;

    word_t     mem [REG_DEPTH] = '{default: '0};
    word_t     rd_q;
    reg_addr_t idx;
    logic      in_range;
    logic      rd_pend;

    assign idx      = addr_i[7:0];
    assign in_range = (addr_i[15:8] == 8'h00);

    // registered read plus one output stage
    always_ff @(posedge clk) begin
        if (valid_i && write_i && in_range) begin
            mem[idx] <= data_i;
        end
        rd_q      <= mem[idx];
        rd_data_o <= rd_q;
    end

    // valid follows the data through both stages
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_pend    <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_pend    <= valid_i && !write_i && in_range;
            rd_valid_o <= rd_pend;
        end
    end

endmodule

//--- rtl/response_formatter.sv
`timescale 1ns/1ps

module response_formatter (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  regbridge_pkg::word_t rd_data_i,
    input  logic                 rd_valid_i,
    output regbridge_pkg::byte_t byte_o,
    output logic                 start_o,
    input  logic                 done_i
);
    import regbridge_pkg::*;

    logic       busy;
    logic [2:0] byte_cnt;
    word_t      word_q;

    function automatic byte_t to_hex(input nibble_t n);
        if (n < 4'd10) begin
            return byte_t'(n) + "0";
        end
        return byte_t'(n) - 8'd10 + "A";
    endfunction

    assign start_o = busy;

    // reply is D, four digits msb first, CR, LF
    always_comb begin
        case (byte_cnt)
            3'd0:    byte_o = CHAR_DATA;
            3'd1:    byte_o = to_hex(word_q[15:12]);
            3'd2:    byte_o = to_hex(word_q[11:8]);
            3'd3:    byte_o = to_hex(word_q[7:4]);
            3'd4:    byte_o = to_hex(word_q[3:0]);
            3'd5:    byte_o = CHAR_CR;
            3'd6:    byte_o = CHAR_LF;
            default: byte_o = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy     <= 1'b0;
            byte_cnt <= '0;
        end else if (!busy) begin
            byte_cnt <= '0;
            busy     <= rd_valid_i;
        end else if (done_i) begin
            if (byte_cnt == 3'd6) begin
                busy     <= 1'b0;
                byte_cnt <= '0;
            end else begin
                byte_cnt <= byte_cnt + 3'd1;
            end
        end
    end

    // reads that land mid reply are lost
    always_ff @(posedge clk) begin
        if (!busy && rd_valid_i) begin
            word_q <= rd_data_i;
        end
    end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  regbridge_pkg::byte_t data_i,
    input  logic                 start_i,
    output logic                 done_o,
    output logic                 tx_o
);
    import regbridge_pkg::*;

    typedef logic [$clog2(CLKS_PER_BAUD)-1:0] baud_cnt_t;

    logic       busy;
    baud_cnt_t  baud_cnt;
    logic [3:0] bit_idx;
    logic [8:0] shreg;
    logic       load;
    logic       tick;

    // wait out the done cycle so the sender can move to its next byte
    assign load = start_i && !busy && !done_o;
    assign tick = busy && (baud_cnt == '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            done_o   <= 1'b0;
            tx_o     <= 1'b1;
        end else begin
            done_o <= 1'b0;
            if (load) begin
                busy     <= 1'b1;
                baud_cnt <= baud_cnt_t'(CLKS_PER_BAUD - 1);
                bit_idx  <= '0;
                tx_o     <= 1'b0;
            end else if (tick) begin
                baud_cnt <= baud_cnt_t'(CLKS_PER_BAUD - 1);
                if (bit_idx == 4'd9) begin
                    // stop bit has ended
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    tx_o    <= shreg[0];
                    bit_idx <= bit_idx + 4'd1;
                end
            end else if (busy) begin
                baud_cnt <= baud_cnt - 1'b1;
            end
        end
    end

    // data bits then stop bit, lsb first
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= {1'b1, data_i};
        end else if (tick && (bit_idx != 4'd9)) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

//--- rtl/regbridge_top.sv
`timescale 1ns/1ps

module regbridge_top (
    input  logic clk,
    input  logic arst_n_i,
    input  logic rx_i,
    output logic tx_o
);
    import regbridge_pkg::*;

    byte_t rx_data;
    logic  rx_valid;
    word_t req_addr;
    word_t req_data;
    logic  req_write;
    logic  req_valid;
    word_t rd_data;
    logic  rd_valid;
    byte_t tx_byte;
    logic  tx_start;
    logic  tx_done;

    // command path
    uart_rx uart_rx_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .rx_i     (rx_i),
        .data_o   (rx_data),
        .valid_o  (rx_valid)
    );

    request_parser request_parser_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .byte_i       (rx_data),
        .byte_valid_i (rx_valid),
        .addr_o       (req_addr),
        .data_o       (req_data),
        .write_o      (req_write),
        .valid_o      (req_valid)
    );

    register_file register_file_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .addr_i     (req_addr),
        .data_i     (req_data),
        .write_i    (req_write),
        .valid_i    (req_valid),
        .rd_data_o  (rd_data),
        .rd_valid_o (rd_valid)
    );

    // reply path
    response_formatter response_formatter_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rd_data_i  (rd_data),
        .rd_valid_i (rd_valid),
        .byte_o     (tx_byte),
        .start_o    (tx_start),
        .done_i     (tx_done)
    );

    uart_tx uart_tx_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .data_i   (tx_byte),
        .start_i  (tx_start),
        .done_o   (tx_done),
        .tx_o     (tx_o)
    );

endmodule

//--- verif/regbridge_chk.sv
`timescale 1ns/1ps

module regbridge_chk (
    input logic                 clk,
    input logic                 arst_n_i,
    input logic                 tx_o,
    input logic                 req_valid,
    input logic                 req_write,
    input regbridge_pkg::word_t req_addr,
    input logic                 rd_valid
);
    int fail_cnt = 0;

    // line idles high while reset is held
    tx_idle_in_reset: assert property (@(posedge clk)
        (!arst_n_i && $past(!arst_n_i)) |-> tx_o)
        else begin
            fail_cnt++;
            $error("tx_o low during reset");
        end

    // parser strobes are single cycle
    req_single_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_valid |=> !req_valid)
        else begin
            fail_cnt++;
            $error("req_valid high in two consecutive cycles");
        end

    read_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        (req_valid && !req_write && (req_addr[15:8] == 8'h00)) |-> ##2 rd_valid)
        else begin
            fail_cnt++;
            $error("rd_valid missing two cycles after a read request");
        end

endmodule

//--- verif/regbridge_tb.sv
`timescale 1ns/1ps

module regbridge_tb;
    import regbridge_pkg::*;

    logic clk;
    logic arst_n_i;
    logic rx_i;
    logic tx_o;

    byte_t        reply_q[$];
    logic [127:0] cmd_q[$];
    int           flag_q[$];
    word_t        exp_q[$];
    int           err_cnt = 0;
    int           check_cnt = 0;
    int           cycle_cnt = 0;
    int           limit_cycles = 0;
    int           seed = 32'hefb3;

    regbridge_top regbridge_top_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .rx_i     (rx_i),
        .tx_o     (tx_o)
    );

    bind regbridge_top regbridge_chk regbridge_chk_inst (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .tx_o      (tx_o),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .rd_valid  (rd_valid)
    );

    always #2 clk = ~clk;

    // run limit, armed once the cases are loaded
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if ((limit_cycles > 0) && (cycle_cnt >= limit_cycles)) begin
            $display("timeout: run did not finish within %0d cycles", limit_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_word(input word_t got, input word_t exp, input string name);
        check_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string name);
        check_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // ascii hex digit to its value, upper case only
    // any other character decodes to x
    function automatic nibble_t hex_value(input byte_t c);
        if ((c >= "0") && (c <= "9")) begin
            return nibble_t'(c - "0");
        end
        if ((c >= "A") && (c <= "F")) begin
            return nibble_t'(c - "A" + 8'd10);
        end
        return 4'hx;
    endfunction

    // 8N1 frame, each bit held for one baud period
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_i <= frame[i];
            repeat (CLKS_PER_BAUD - 1) @(posedge clk);
        end
    endtask

    task automatic send_command(input logic [127:0] cmd);
        for (int i = 15; i >= 0; i--) begin
            if (cmd[i*8 +: 8] != 8'h00) begin
                send_byte(cmd[i*8 +: 8]);
            end
        end
        send_byte(CHAR_CR);
    endtask

    // samples tx_o in the middle of each bit
    task automatic decode_replies();
        byte_t b;
        forever begin
            @(posedge clk);
            if (tx_o == 1'b0) begin
                repeat (CLKS_PER_BAUD / 2) @(posedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BAUD) @(posedge clk);
                    b[i] = tx_o;
                end
                repeat (CLKS_PER_BAUD) @(posedge clk);
                if (tx_o !== 1'b1) begin
                    $display("reply byte at %0d ns has a low stop bit", $time);
                    err_cnt++;
                end
                reply_q.push_back(b);
            end
        end
    endtask

    task automatic expect_reply(input word_t exp);
        int    waited;
        word_t got;
        waited = 0;
        while ((reply_q.size() < 7) && (waited < 80 * CLKS_PER_BAUD)) begin
            @(posedge clk);
            waited++;
        end
        if (reply_q.size() < 7) begin
            $display("no complete reply by %0d ns, expected word %h", $time, exp);
            err_cnt++;
        end else begin
            got = {hex_value(reply_q[1]), hex_value(reply_q[2]),
                   hex_value(reply_q[3]), hex_value(reply_q[4])};
            check_byte(reply_q[0], CHAR_DATA, "reply lead");
            check_word(got, exp, "reply word");
            check_byte(reply_q[5], CHAR_CR, "reply cr");
            check_byte(reply_q[6], CHAR_LF, "reply lf");
        end
        reply_q.delete();
    endtask

    task automatic expect_silence();
        repeat (80 * CLKS_PER_BAUD) @(posedge clk);
        check_cnt++;
        if (reply_q.size() != 0) begin
            $display("unexpected reply of %0d bytes by %0d ns", reply_q.size(), $time);
            err_cnt++;
            reply_q.delete();
        end
    endtask

    initial begin
        int           fd;
        int           n_read;
        logic [639:0] line;
        logic [127:0] cmd;
        int           flag;
        word_t        exp_word;
        int           gap;
        int           chk_fails;
        clk      = 1'b0;
        arst_n_i = 1'b0;
        rx_i     = 1'b1;

        fd = $fopen("verif/regbridge_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/regbridge_cases.txt");
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    n_read = $sscanf(line, "%s %d %h", cmd, flag, exp_word);
                    if (n_read == 3) begin
                        cmd_q.push_back(cmd);
                        flag_q.push_back(flag);
                        exp_q.push_back(exp_word);
                    end
                end
            end
            $fclose(fd);
        end
        limit_cycles = cmd_q.size() * 30 * 10 * CLKS_PER_BAUD;

        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;

        fork
            decode_replies();
        join_none

        // idle line, nothing may come out before the first read
        expect_silence();

        for (int c = 0; c < cmd_q.size(); c++) begin
            send_command(cmd_q[c]);
            if (flag_q[c] != 0) begin
                expect_reply(exp_q[c]);
            end else begin
                expect_silence();
            end
            gap = 2 + ($random(seed) & 15);
            repeat (gap) @(posedge clk);
        end

        repeat (10 * CLKS_PER_BAUD) @(posedge clk);
        chk_fails = regbridge_top_inst.regbridge_chk_inst.fail_cnt;
        $display("cases %0d, checks %0d, errors %0d, assertion failures %0d",
                 cmd_q.size(), check_cnt, err_cnt, chk_fails);
        if ((err_cnt == 0) && (chk_fails == 0) && (cmd_q.size() > 0)) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verif/regbridge_cases.txt
# columns: command sent with a CR terminator, reply flag, expected reply word in hex
# a flag of 0 means that no reply may appear
W00120ABC 0 0000
R0012 1 0ABC
W00011111 0 0000
W00FF2222 0 0000
W00803333 0 0000
R0001 1 1111
R00FF 1 2222
R0080 1 3333
W00014444 0 0000
R0001 1 4444
W0080abcd 0 0000
W00805555X 0 0000
X00805555 0 0000
w00015555 0 0000
R0080 1 3333
R0001 1 4444
W0112BEEF 0 0000
R0112 0 0000
R0012 1 0ABC

//--- regbridge_top.f
rtl/regbridge_pkg.sv
rtl/uart_rx.sv
rtl/request_parser.sv
rtl/register_file.sv
rtl/response_formatter.sv
rtl/uart_tx.sv
rtl/regbridge_top.sv
verif/regbridge_chk.sv
verif/regbridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the register bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module regbridge_tb -f regbridge_top.f -o regbridge_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/regbridge_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$log"; then
    exit 1
fi
exit 0
